// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  localparam int DATA_W = 16;
  localparam int ADDR_W = 8;
  localparam int REG_AW = 3;

  // call writes its return address here
  localparam logic [REG_AW-1:0] LINK_REG = 3'd7;

  typedef enum logic [3:0] {
    OP_MV   = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_CMP  = 4'd3,
    OP_LD   = 4'd4,
    OP_ST   = 4'd5,
    OP_MVHI = 4'd6,
    OP_JR   = 4'd8,
    OP_JZ   = 4'd9,
    OP_JN   = 4'd10,
    OP_CALL = 4'd12,
    OP_HALT = 4'd15
  } opcode_e;

  typedef enum logic [2:0] {
    S_FETCH,
    S_LD_IR,
    S_EXECUTE,
    S_MEM_WAIT,
    S_MEM_LD,
    S_HALT
  } state_e;

  // write-back select
  localparam logic [2:0] RF_SEL_IMM  = 3'd0;
  localparam logic [2:0] RF_SEL_HI   = 3'd1;
  localparam logic [2:0] RF_SEL_ALU  = 3'd2;
  localparam logic [2:0] RF_SEL_LINK = 3'd3;
  localparam logic [2:0] RF_SEL_MEM  = 3'd4;
  localparam logic [2:0] RF_SEL_RY   = 3'd5;

  // next pc select
  localparam logic [1:0] PC_SEL_REG = 2'd0;
  localparam logic [1:0] PC_SEL_INC = 2'd1;
  localparam logic [1:0] PC_SEL_REL = 2'd2;

  localparam logic ADDR_SEL_PC = 1'b0;
  localparam logic ADDR_SEL_RY = 1'b1;

  localparam logic ALU_ADD = 1'b0;
  localparam logic ALU_SUB = 1'b1;

endpackage

`default_nettype wire

// ==== src/cpu_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
  input  wire logic                       i_clk,
  input  wire logic                       i_reset,
  input  wire logic                       i_we,
  input  wire logic [cpu_pkg::REG_AW-1:0] i_waddr,
  input  wire logic [cpu_pkg::DATA_W-1:0] i_wdata,
  input  wire logic [cpu_pkg::REG_AW-1:0] i_raddr_a,
  input  wire logic [cpu_pkg::REG_AW-1:0] i_raddr_b,
  output logic      [cpu_pkg::DATA_W-1:0] o_rdata_a,
  output logic      [cpu_pkg::DATA_W-1:0] o_rdata_b
);

  logic [cpu_pkg::DATA_W-1:0] regs [2**cpu_pkg::REG_AW];

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      regs <= '{default: '0};
    end else if (i_we) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata_a = regs[i_raddr_a];
  assign o_rdata_b = regs[i_raddr_b];

endmodule

`default_nettype wire

// ==== src/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
  input  wire logic                       i_clk,
  input  wire logic                       i_reset,
  input  wire logic [cpu_pkg::DATA_W-1:0] i_a,
  input  wire logic [cpu_pkg::DATA_W-1:0] i_b,
  input  wire logic                       i_op,
  input  wire logic                       i_flags_ld,
  output logic      [cpu_pkg::DATA_W-1:0] o_result,
  output logic                            o_n,
  output logic                            o_z
);

  always_comb begin
    if (i_op == cpu_pkg::ALU_SUB) begin
      o_result = i_a - i_b;
    end else begin
      o_result = i_a + i_b;
    end
  end

  // flags hold until the next add, sub or cmp
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      o_n <= 1'b0;
      o_z <= 1'b0;
    end else if (i_flags_ld) begin
      o_n <= o_result[cpu_pkg::DATA_W-1];
      o_z <= (o_result == '0);
    end
  end

endmodule

`default_nettype wire

// ==== src/cpu_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_pc (
  input  wire logic                       i_clk,
  input  wire logic                       i_reset,
  input  wire logic                       i_pc_ld,
  input  wire logic [1:0]                 i_pc_sel,
  input  wire logic [cpu_pkg::ADDR_W-1:0] i_reg_target,
  input  wire logic [7:0]                 i_imm8,
  output logic      [cpu_pkg::ADDR_W-1:0] o_pc,
  output logic      [cpu_pkg::ADDR_W-1:0] o_pc_inc
);

  logic [cpu_pkg::ADDR_W-1:0] pc_next;

  assign o_pc_inc = o_pc + 1'b1;

  // 8-bit add wraps, so the sign extension of imm8 drops out
  always_comb begin
    case (i_pc_sel)
      cpu_pkg::PC_SEL_REG: pc_next = i_reg_target;
      cpu_pkg::PC_SEL_REL: pc_next = o_pc + i_imm8;
      default:             pc_next = o_pc_inc;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      o_pc <= '0;
    end else if (i_pc_ld) begin
      o_pc <= pc_next;
    end
  end

endmodule

`default_nettype wire

// ==== src/cpu_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_datapath (
  input  wire logic                       i_clk,
  input  wire logic                       i_reset,
  input  wire logic                       i_ir_ld,
  input  wire logic [cpu_pkg::DATA_W-1:0] i_rdata,
  input  wire logic [2:0]                 i_rf_sel,
  input  wire logic                       i_rf_write,
  input  wire logic                       i_rf_addr_w_sel,
  input  wire logic                       i_alu_b_sel,
  input  wire logic                       i_alu_op,
  input  wire logic                       i_alu_flags_ld,
  input  wire logic                       i_addr_sel,
  input  wire logic [cpu_pkg::ADDR_W-1:0] i_pc,
  input  wire logic [cpu_pkg::ADDR_W-1:0] i_pc_inc,
  output cpu_pkg::opcode_e                o_ir_op,
  output logic                            o_ir_mode,
  output logic      [7:0]                 o_imm8,
  output logic      [cpu_pkg::DATA_W-1:0] o_ry_value,
  output logic                            o_alu_n,
  output logic                            o_alu_z,
  output logic      [cpu_pkg::ADDR_W-1:0] o_mem_addr,
  output logic      [cpu_pkg::DATA_W-1:0] o_mem_wdata
);

  logic [cpu_pkg::DATA_W-1:0] ir;
  logic [cpu_pkg::REG_AW-1:0] rx;
  logic [cpu_pkg::REG_AW-1:0] ry;
  logic [cpu_pkg::REG_AW-1:0] waddr;
  logic [cpu_pkg::DATA_W-1:0] rx_value;
  logic [cpu_pkg::DATA_W-1:0] imm_sext;
  logic [cpu_pkg::DATA_W-1:0] alu_b;
  logic [cpu_pkg::DATA_W-1:0] alu_result;
  logic [cpu_pkg::DATA_W-1:0] wdata;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      ir <= '0;
    end else if (i_ir_ld) begin
      ir <= i_rdata;
    end
  end

  assign o_ir_op   = cpu_pkg::opcode_e'(ir[3:0]);
  assign o_ir_mode = ir[4];
  assign rx        = ir[7:5];
  assign ry        = ir[10:8];
  // imm8 shares bits with ry
  assign o_imm8    = ir[15:8];
  assign imm_sext  = {{(cpu_pkg::DATA_W - 8){o_imm8[7]}}, o_imm8};

  assign waddr = i_rf_addr_w_sel ? cpu_pkg::LINK_REG : rx;
  assign alu_b = i_alu_b_sel ? o_ry_value : imm_sext;

  always_comb begin
    case (i_rf_sel)
      cpu_pkg::RF_SEL_IMM:  wdata = imm_sext;
      cpu_pkg::RF_SEL_HI:   wdata = {o_imm8, rx_value[7:0]};
      cpu_pkg::RF_SEL_LINK: wdata = {{(cpu_pkg::DATA_W - cpu_pkg::ADDR_W){1'b0}}, i_pc_inc};
      cpu_pkg::RF_SEL_MEM:  wdata = i_rdata;
      cpu_pkg::RF_SEL_RY:   wdata = o_ry_value;
      default:              wdata = alu_result;
    endcase
  end

  assign o_mem_addr  = (i_addr_sel == cpu_pkg::ADDR_SEL_RY) ?
                       o_ry_value[cpu_pkg::ADDR_W-1:0] : i_pc;
  assign o_mem_wdata = rx_value;

  cpu_regfile u_regfile (
    .i_clk     (i_clk),
    .i_reset   (i_reset),
    .i_we      (i_rf_write),
    .i_waddr   (waddr),
    .i_wdata   (wdata),
    .i_raddr_a (rx),
    .i_raddr_b (ry),
    .o_rdata_a (rx_value),
    .o_rdata_b (o_ry_value)
  );

  cpu_alu u_alu (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_a        (rx_value),
    .i_b        (alu_b),
    .i_op       (i_alu_op),
    .i_flags_ld (i_alu_flags_ld),
    .o_result   (alu_result),
    .o_n        (o_alu_n),
    .o_z        (o_alu_z)
  );

endmodule

`default_nettype wire

// ==== src/cpu_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
  input  wire logic             i_clk,
  input  wire logic             i_reset,
  input  wire cpu_pkg::opcode_e i_ir_op,
  input  wire logic             i_ir_mode,
  input  wire logic             i_alu_n,
  input  wire logic             i_alu_z,
  input  wire logic             i_mem_done,
  output logic                  o_mem_rd,
  output logic                  o_mem_wr,
  output logic                  o_addr_sel,
  output logic [1:0]            o_pc_sel,
  output logic                  o_pc_ld,
  output logic                  o_ir_ld,
  output logic [2:0]            o_rf_sel,
  output logic                  o_rf_write,
  output logic                  o_rf_addr_w_sel,
  output logic                  o_alu_b_sel,
  output logic                  o_alu_op,
  output logic                  o_alu_flags_ld,
  output logic                  o_halted
);

  cpu_pkg::state_e state;
  cpu_pkg::state_e nextstate;
  logic [1:0]      jump_sel;

  // register form jumps to ry, immediate form is pc relative
  assign jump_sel = i_ir_mode ? cpu_pkg::PC_SEL_REL : cpu_pkg::PC_SEL_REG;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      state <= cpu_pkg::S_FETCH;
    end else begin
      state <= nextstate;
    end
  end

  always_comb begin
    nextstate       = state;
    o_mem_rd        = 1'b0;
    o_mem_wr        = 1'b0;
    o_addr_sel      = cpu_pkg::ADDR_SEL_PC;
    o_pc_sel        = cpu_pkg::PC_SEL_INC;
    o_pc_ld         = 1'b0;
    o_ir_ld         = 1'b0;
    o_rf_sel        = cpu_pkg::RF_SEL_ALU;
    o_rf_write      = 1'b0;
    o_rf_addr_w_sel = 1'b0;
    o_alu_b_sel     = ~i_ir_mode;
    o_alu_op        = cpu_pkg::ALU_ADD;
    o_alu_flags_ld  = 1'b0;
    o_halted        = 1'b0;

    case (state)
      cpu_pkg::S_FETCH: begin
        o_mem_rd = 1'b1;
        if (i_mem_done) begin
          nextstate = cpu_pkg::S_LD_IR;
        end
      end

      cpu_pkg::S_LD_IR: begin
        o_ir_ld   = 1'b1;
        nextstate = cpu_pkg::S_EXECUTE;
      end

      cpu_pkg::S_EXECUTE: begin
        nextstate = cpu_pkg::S_FETCH;
        o_pc_ld   = 1'b1;
        case (i_ir_op)
          cpu_pkg::OP_MV: begin
            o_rf_write = 1'b1;
            o_rf_sel   = i_ir_mode ? cpu_pkg::RF_SEL_IMM : cpu_pkg::RF_SEL_RY;
          end
          cpu_pkg::OP_ADD, cpu_pkg::OP_SUB: begin
            o_rf_write     = 1'b1;
            o_alu_flags_ld = 1'b1;
            o_alu_op = (i_ir_op == cpu_pkg::OP_SUB) ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
          end
          // flags only
          cpu_pkg::OP_CMP: begin
            o_alu_flags_ld = 1'b1;
            o_alu_op       = cpu_pkg::ALU_SUB;
          end
          cpu_pkg::OP_LD: begin
            o_mem_rd   = 1'b1;
            o_addr_sel = cpu_pkg::ADDR_SEL_RY;
            nextstate  = cpu_pkg::S_MEM_WAIT;
          end
          cpu_pkg::OP_ST: begin
            o_mem_wr   = 1'b1;
            o_addr_sel = cpu_pkg::ADDR_SEL_RY;
            nextstate  = cpu_pkg::S_MEM_WAIT;
          end
          cpu_pkg::OP_MVHI: begin
            o_rf_write = 1'b1;
            o_rf_sel   = cpu_pkg::RF_SEL_HI;
          end
          cpu_pkg::OP_JR: begin
            o_pc_sel = jump_sel;
          end
          cpu_pkg::OP_JZ: begin
            if (i_alu_z) begin
              o_pc_sel = jump_sel;
            end
          end
          cpu_pkg::OP_JN: begin
            if (i_alu_n) begin
              o_pc_sel = jump_sel;
            end
          end
          cpu_pkg::OP_CALL: begin
            o_pc_sel        = jump_sel;
            o_rf_write      = 1'b1;
            o_rf_sel        = cpu_pkg::RF_SEL_LINK;
            o_rf_addr_w_sel = 1'b1;
          end
          // halt and anything undefined
          default: begin
            o_pc_ld   = 1'b0;
            nextstate = cpu_pkg::S_HALT;
          end
        endcase
      end

      // hold the request until the port finishes
      cpu_pkg::S_MEM_WAIT: begin
        o_mem_rd   = (i_ir_op == cpu_pkg::OP_LD);
        o_mem_wr   = (i_ir_op == cpu_pkg::OP_ST);
        o_addr_sel = cpu_pkg::ADDR_SEL_RY;
        if (i_mem_done) begin
          nextstate = (i_ir_op == cpu_pkg::OP_LD) ? cpu_pkg::S_MEM_LD : cpu_pkg::S_FETCH;
        end
      end

      cpu_pkg::S_MEM_LD: begin
        o_rf_sel   = cpu_pkg::RF_SEL_MEM;
        o_rf_write = 1'b1;
        nextstate  = cpu_pkg::S_FETCH;
      end

      cpu_pkg::S_HALT: begin
        o_halted = 1'b1;
      end

      default: begin
        nextstate = cpu_pkg::S_HALT;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/cpu_mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_port (
  input  wire logic                       i_clk,
  input  wire logic                       i_reset,
  input  wire logic                       i_rd,
  input  wire logic                       i_wr,
  input  wire logic [cpu_pkg::ADDR_W-1:0] i_addr,
  input  wire logic [cpu_pkg::DATA_W-1:0] i_wdata,
  input  wire logic                       i_mem_ack,
  input  wire logic [cpu_pkg::DATA_W-1:0] i_mem_rdata,
  output logic                            o_mem_req,
  output logic                            o_mem_we,
  output logic      [cpu_pkg::ADDR_W-1:0] o_mem_addr,
  output logic      [cpu_pkg::DATA_W-1:0] o_mem_wdata,
  output logic      [cpu_pkg::DATA_W-1:0] o_rdata,
  output logic                            o_done
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_REQ,
    PH_RELEASE
  } phase_e;

  phase_e phase;

  assign o_mem_req = (phase == PH_REQ);

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      phase    <= PH_IDLE;
      o_mem_we <= 1'b0;
      o_done   <= 1'b0;
    end else begin
      o_done <= 1'b0;
      case (phase)
        // the control still requests during the done cycle
        PH_IDLE: begin
          if ((i_rd || i_wr) && !o_done) begin
            phase    <= PH_REQ;
            o_mem_we <= i_wr;
          end
        end
        PH_REQ: begin
          if (i_mem_ack) begin
            phase <= PH_RELEASE;
          end
        end
        PH_RELEASE: begin
          if (!i_mem_ack) begin
            phase  <= PH_IDLE;
            o_done <= 1'b1;
          end
        end
        default: begin
          phase <= PH_IDLE;
        end
      endcase
    end
  end

  // bus payload and read capture
  always_ff @(posedge i_clk) begin
    if (phase == PH_IDLE && (i_rd || i_wr) && !o_done) begin
      o_mem_addr  <= i_addr;
      o_mem_wdata <= i_wdata;
    end
    if (phase == PH_REQ && i_mem_ack) begin
      o_rdata <= i_mem_rdata;
    end
  end

endmodule

`default_nettype wire

// ==== src/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
  input  wire logic                       i_clk,
  input  wire logic                       i_reset,
  input  wire logic                       i_mem_ack,
  input  wire logic [cpu_pkg::DATA_W-1:0] i_mem_rdata,
  output logic                            o_mem_req,
  output logic                            o_mem_we,
  output logic      [cpu_pkg::ADDR_W-1:0] o_mem_addr,
  output logic      [cpu_pkg::DATA_W-1:0] o_mem_wdata,
  output logic                            o_halted
);

  cpu_pkg::opcode_e           ir_op;
  logic                       ir_mode;
  logic [7:0]                 imm8;
  logic                       alu_n;
  logic                       alu_z;
  logic                       mem_rd;
  logic                       mem_wr;
  logic                       mem_done;
  logic                       addr_sel;
  logic [1:0]                 pc_sel;
  logic                       pc_ld;
  logic                       ir_ld;
  logic [2:0]                 rf_sel;
  logic                       rf_write;
  logic                       rf_addr_w_sel;
  logic                       alu_b_sel;
  logic                       alu_op;
  logic                       alu_flags_ld;
  logic [cpu_pkg::ADDR_W-1:0] pc;
  logic [cpu_pkg::ADDR_W-1:0] pc_inc;
  logic [cpu_pkg::DATA_W-1:0] ry_value;
  logic [cpu_pkg::ADDR_W-1:0] cpu_addr;
  logic [cpu_pkg::DATA_W-1:0] cpu_wdata;
  logic [cpu_pkg::DATA_W-1:0] rdata;

  cpu_control u_control (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_ir_op         (ir_op),
    .i_ir_mode       (ir_mode),
    .i_alu_n         (alu_n),
    .i_alu_z         (alu_z),
    .i_mem_done      (mem_done),
    .o_mem_rd        (mem_rd),
    .o_mem_wr        (mem_wr),
    .o_addr_sel      (addr_sel),
    .o_pc_sel        (pc_sel),
    .o_pc_ld         (pc_ld),
    .o_ir_ld         (ir_ld),
    .o_rf_sel        (rf_sel),
    .o_rf_write      (rf_write),
    .o_rf_addr_w_sel (rf_addr_w_sel),
    .o_alu_b_sel     (alu_b_sel),
    .o_alu_op        (alu_op),
    .o_alu_flags_ld  (alu_flags_ld),
    .o_halted        (o_halted)
  );

  cpu_pc u_pc (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_pc_ld      (pc_ld),
    .i_pc_sel     (pc_sel),
    .i_reg_target (ry_value[cpu_pkg::ADDR_W-1:0]),
    .i_imm8       (imm8),
    .o_pc         (pc),
    .o_pc_inc     (pc_inc)
  );

  cpu_datapath u_datapath (
    .i_clk           (i_clk),
    .i_reset         (i_reset),
    .i_ir_ld         (ir_ld),
    .i_rdata         (rdata),
    .i_rf_sel        (rf_sel),
    .i_rf_write      (rf_write),
    .i_rf_addr_w_sel (rf_addr_w_sel),
    .i_alu_b_sel     (alu_b_sel),
    .i_alu_op        (alu_op),
    .i_alu_flags_ld  (alu_flags_ld),
    .i_addr_sel      (addr_sel),
    .i_pc            (pc),
    .i_pc_inc        (pc_inc),
    .o_ir_op         (ir_op),
    .o_ir_mode       (ir_mode),
    .o_imm8          (imm8),
    .o_ry_value      (ry_value),
    .o_alu_n         (alu_n),
    .o_alu_z         (alu_z),
    .o_mem_addr      (cpu_addr),
    .o_mem_wdata     (cpu_wdata)
  );

  cpu_mem_port u_mem_port (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_rd        (mem_rd),
    .i_wr        (mem_wr),
    .i_addr      (cpu_addr),
    .i_wdata     (cpu_wdata),
    .i_mem_ack   (i_mem_ack),
    .i_mem_rdata (i_mem_rdata),
    .o_mem_req   (o_mem_req),
    .o_mem_we    (o_mem_we),
    .o_mem_addr  (o_mem_addr),
    .o_mem_wdata (o_mem_wdata),
    .o_rdata     (rdata),
    .o_done      (mem_done)
  );

endmodule

`default_nettype wire

// ==== verification/cpu_tb_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb_assert (
  input wire logic                       i_clk,
  input wire logic                       i_reset,
  input wire logic                       i_rd,
  input wire logic                       i_wr,
  input wire logic                       i_mem_req,
  input wire logic                       i_mem_ack,
  input wire logic                       i_mem_we,
  input wire logic [cpu_pkg::ADDR_W-1:0] i_mem_addr,
  input wire logic [cpu_pkg::DATA_W-1:0] i_mem_wdata
);

  // number of failed bus checks so far
  int unsigned fail_count = 0;

  // req waits for the slave
  req_held: assert property (@(posedge i_clk) disable iff (i_reset)
    i_mem_req && !i_mem_ack |=> i_mem_req)
    else begin
      $error("bus req dropped before ack");
      fail_count++;
    end

  payload_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    i_mem_req |=> !i_mem_req || $stable({i_mem_addr, i_mem_we, i_mem_wdata}))
    else begin
      $error("bus address, we or wdata changed while req was high");
      fail_count++;
    end

  // previous ack must be gone before a new req
  req_after_ack: assert property (@(posedge i_clk) disable iff (i_reset)
    $rose(i_mem_req) |-> !i_mem_ack)
    else begin
      $error("bus req rose while ack was still high");
      fail_count++;
    end

  rd_wr_exclusive: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_rd && i_wr))
    else begin
      $error("read and write requested together");
      fail_count++;
    end

endmodule

bind cpu_mem_port cpu_tb_assert u_bus_assert (
  .i_clk       (i_clk),
  .i_reset     (i_reset),
  .i_rd        (i_rd),
  .i_wr        (i_wr),
  .i_mem_req   (o_mem_req),
  .i_mem_ack   (i_mem_ack),
  .i_mem_we    (o_mem_we),
  .i_mem_addr  (o_mem_addr),
  .i_mem_wdata (o_mem_wdata)
);

`default_nettype wire

// ==== verification/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  logic        clk;
  logic        reset = 1'b1;
  logic        mem_ack = 1'b0;
  logic [15:0] mem_rdata = 16'h0000;
  logic        mem_req;
  logic        mem_we;
  logic [7:0]  mem_addr;
  logic [15:0] mem_wdata;
  logic        halted;

  logic [31:0] stim [0:63];
  logic [15:0] mem [0:255];
  logic [23:0] expected_q [$];
  int          stores_seen = 0;
  int          halt_count;
  logic [31:0] rng;
  logic [1:0]  ack_wait;

  cpu_top uut (
    .i_clk       (clk),
    .i_reset     (reset),
    .i_mem_ack   (mem_ack),
    .i_mem_rdata (mem_rdata),
    .o_mem_req   (mem_req),
    .o_mem_we    (mem_we),
    .o_mem_addr  (mem_addr),
    .o_mem_wdata (mem_wdata),
    .o_halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped after the first failure");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      fail_run($sformatf("[ERROR] %0t ns: %s: got 0x%0h, expected 0x%0h",
                         $time, what, actual, expected));
    end
  endtask

  // next expected store is {addr, data}
  task automatic check_store(input logic [7:0] addr, input logic [15:0] data);
    logic [23:0] expected;
    if (expected_q.size() == 0) begin
      fail_run($sformatf("the CPU made an unexpected extra store of %h to address %h",
                         data, addr));
    end else begin
      expected = expected_q.pop_front();
      check_value({8'h00, addr, data}, {8'h00, expected},
                  $sformatf("store %0d address and data", stores_seen));
      stores_seen++;
    end
  endtask

  task automatic load_stimulus();
    logic [31:0] entry;
    int          a;
    halt_count = -1;
    for (a = 0; a < 256; a++) begin
      mem[a] = {a[7:0] ^ 8'h5a, ~a[7:0]};
    end
    $readmemh("verification/cpu_stimulus.txt", stim);
    for (a = 0; a < 64; a++) begin
      entry = stim[a];
      case (entry[31:28])
        4'h1: mem[entry[23:16]] = entry[15:0];
        4'h2: expected_q.push_back(entry[23:0]);
        4'hf: halt_count = entry[15:0];
        default: ;
      endcase
    end
  endtask

  // four-phase memory slave with a random ack delay
  always @(posedge clk) begin
    if (reset) begin
      mem_ack  <= 1'b0;
      ack_wait <= 2'd0;
      rng      <= 32'hf86f136c;
    end else if (mem_req && !mem_ack) begin
      if (ack_wait == 2'd0) begin
        mem_ack   <= 1'b1;
        mem_rdata <= mem[mem_addr];
        if (mem_we) begin
          mem[mem_addr] <= mem_wdata;
          check_store(mem_addr, mem_wdata);
        end
        rng      <= xorshift32(rng);
        ack_wait <= rng[1:0];
      end else begin
        ack_wait <= ack_wait - 2'd1;
      end
    end else if (!mem_req && mem_ack) begin
      mem_ack <= 1'b0;
    end
  end

  // a failed bus assertion ends the run
  always @(posedge clk) begin
    if (uut.u_mem_port.u_bus_assert.fail_count != 0) begin
      fail_run("a bus protocol assertion failed");
    end
  end

  initial begin : main
    int cycles;
    load_stimulus();
    if (halt_count < 0) begin
      fail_run("the stimulus file has no halt entry");
    end
    repeat (16) @(posedge clk);
    reset <= 1'b0;

    // first fetch right after reset
    cycles = 0;
    while (!mem_req && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (!mem_req) begin
      fail_run("timed out waiting for the first instruction fetch after reset");
    end

    cycles = 0;
    while (!halted && cycles < 5000) begin
      @(negedge clk);
      cycles++;
    end
    if (!halted) begin
      fail_run("timed out waiting for the CPU to halt");
    end

    repeat (4) @(negedge clk);
    check_value({31'd0, mem_req}, 32'd0, "bus request after halt");
    check_value({31'd0, halted}, 32'd1, "halted flag after halt");

    if (uut.u_mem_port.u_bus_assert.fail_count != 0) begin
      fail_run("a bus protocol assertion failed");
    end

    if (expected_q.size() != 0 || stores_seen != halt_count) begin
      fail_run($sformatf("the CPU halted after %0d stores, but %0d were expected",
                         stores_seen, halt_count));
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== cpu_top.f ====
src/cpu_pkg.sv
src/cpu_regfile.sv
src/cpu_alu.sv
src/cpu_pc.sv
src/cpu_datapath.sv
src/cpu_control.sv
src/cpu_mem_port.sv
src/cpu_top.sv
verification/cpu_tb_assert.sv
verification/cpu_tb.sv

// ==== verification/cpu_stimulus.txt ====
// columns: tag(1 hex) 0 addr(2 hex) data(4 hex)
// tag 1 program word, tag 2 expected store in order, tag f halt after data stores
100040D0 // 00 mvi r6, 0x40
1001FD30 // 01 mvi r1, 0xfd
10021236 // 02 mvhi r1, 0x12
10030625 // 03 st r1, [r6]
10040140 // 04 mv r2, r1
10057F51 // 05 addi r2, 0x7f
100601D1 // 06 addi r6, 1
10070645 // 07 st r2, [r6]
10080570 // 08 mvi r3, 5
10090262 // 09 sub r3, r2
100A01D1 // 0a addi r6, 1
100B0665 // 0b st r3, [r6]
100C0161 // 0c add r3, r1
100D8072 // 0d subi r3, 0x80
100E01D1 // 0e addi r6, 1
100F0665 // 0f st r3, [r6]
10106090 // 10 mvi r4, 0x60
101104A4 // 11 ld r5, [r4]
101201D1 // 12 addi r6, 1
101306A5 // 13 st r5, [r6]
10140A10 // 14 mvi r0, 0x0a
10150673 // 15 cmpi r3, 6
10160219 // 16 jz +2, taken
10170B10 // 17 mvi r0, 0x0b
101801D1 // 18 addi r6, 1
10190605 // 19 st r0, [r6]
101A0773 // 1a cmpi r3, 7
101B0219 // 1b jz +2, not taken
101C0C10 // 1c mvi r0, 0x0c
101D021A // 1d jn +2, taken
101E0D10 // 1e mvi r0, 0x0d
101F01D1 // 1f addi r6, 1
10200605 // 20 st r0, [r6]
1021041C // 21 call +4, link 0x22
102201D1 // 22 addi r6, 1
102306C5 // 23 st r6, [r6]
1024000F // 24 halt
102501D1 // 25 addi r6, 1
102606E5 // 26 st r7, [r6]
10270708 // 27 jr r7
1060A5C3 // data word for ld
204012FD
2041137C
2042EC89
20430006
2044A5C3
2045000A
2046000C
20470022
20480048
F0000009
